/* logic/dma_pkg.sv */
package dma_pkg;

  ////////////////////////////////////////
  // Sizes

  // Channels sharing the one memory port
  localparam int dma_channels = 4;
  // Enough bits to name any channel
  localparam int dma_chan_w = 2;

  localparam int dma_addr_w = 16;
  localparam int dma_data_w = 32;
  // Word count per descriptor
  localparam int dma_len_w = 16;

  ////////////////////////////////////////
  // Descriptor register selects

  localparam logic [1:0] dma_reg_src = 2'd0;
  localparam logic [1:0] dma_reg_dst = 2'd1;
  // Length plus start bit
  localparam logic [1:0] dma_reg_ctrl = 2'd2;

  ////////////////////////////////////////
  // Engine sequencer states

  localparam int dma_st_w = 2;
  // Waiting for run and a request
  localparam logic [dma_st_w-1:0] dma_st_idle = 2'd0;
  // Source word fetched
  localparam logic [dma_st_w-1:0] dma_st_read = 2'd1;
  // Destination word written, step pulsed
  localparam logic [dma_st_w-1:0] dma_st_write = 2'd2;

  ////////////////////////////////////////
  // Host configuration word

  // Same 32 bits seen as an address (src/dst) or as a control word
  typedef union packed {
    struct packed {
      logic [dma_data_w-dma_addr_w-1:0] rsvd;
      logic [dma_addr_w-1:0]            addr;
    } addr;
    struct packed {
      // Arms the channel when length is nonzero
      logic                             start;
      logic [dma_data_w-dma_len_w-2:0]  rsvd;
      logic [dma_len_w-1:0]             len;
    } ctrl;
  } dma_cfg_word_t;

endpackage

/* logic/dma_arb_rr.sv */
module dma_arb_rr #(
  parameter int n = 4
) (
  input  logic [n-1:0] req,
  input  logic         en,
  input  logic [n-1:0] gnt,
  output logic [n-1:0] nxt_gnt
);

  ////////////////////////////////////////
  // Precedence masks

  // A one in mask[i][p] means requester p is served before i
  wire [n-1:0] mask [n];

  genvar i;
  genvar j;
  genvar k;

  for (i = 0; i < n; i++) begin : g_mask
    // A requester never blocks itself
    assign mask[i][i] = 1'b0;

    // Walk downward from i, wrapping, until the current holder is met
    for (j = 1; j < n; j++) begin : g_walk
      if (j == 1) begin : g_first
        // Neighbour just below us ranks higher unless it holds the grant
        assign mask[i][(i - j + n) % n] = ~gnt[(i - j + n) % n];
      end else begin : g_next
        // Keep filling ones only while the holder is still ahead
        assign mask[i][(i - j + n) % n] =
          mask[i][(i - j + 1 + n) % n] & ~gnt[(i - j + n) % n];
      end
    end
  end

  ////////////////////////////////////////
  // Next grant

  // Holder itself ends with the lowest priority
  for (k = 0; k < n; k++) begin : g_nxt
    // Win when nobody ahead is requesting
    // With no requests at all the old holder keeps the grant
    assign nxt_gnt[k] = en ?
      ((~|(mask[k] & req) & req[k]) | (~|req & gnt[k])) :
      gnt[k];
  end

endmodule

/* logic/dma_channel.sv */
module dma_channel #(
  parameter int chan_idx = 0
) (
  input  logic                            clk,
  input  logic                            arst_n,
  // Host configuration write
  input  logic                            cfg_we,
  input  logic [dma_pkg::dma_chan_w-1:0]  cfg_chan,
  input  logic [1:0]                      cfg_reg,
  input  dma_pkg::dma_cfg_word_t          cfg_wdata,
  // One pulse per word written for this channel
  input  logic                            step,
  output logic                            req,
  output logic [dma_pkg::dma_addr_w-1:0]  src_addr,
  output logic [dma_pkg::dma_addr_w-1:0]  dst_addr,
  output logic                            done
);

  import dma_pkg::*;

  ////////////////////////////////////////
  // Write decode

  logic                 sel;
  logic                 idle;
  logic                 wr_src;
  logic                 wr_dst;
  logic                 wr_start;
  logic                 last_step;
  logic [dma_len_w-1:0] remaining;

  // Only writes aimed at this channel count
  assign sel = cfg_we && (cfg_chan == dma_chan_w'(chan_idx));

  // Idle means no words left to move
  assign idle = !req;

  // Descriptor is frozen while a copy runs
  assign wr_src = sel && idle && (cfg_reg == dma_reg_src);
  assign wr_dst = sel && idle && (cfg_reg == dma_reg_dst);

  // Start with zero length falls through and does nothing
  assign wr_start = sel && idle && (cfg_reg == dma_reg_ctrl) &&
                    cfg_wdata.ctrl.start && (cfg_wdata.ctrl.len != '0);

  // Final word of the descriptor
  assign last_step = step && (remaining == dma_len_w'(1));

  ////////////////////////////////////////
  // Address counters

  always_ff @(posedge clk) begin
    if (wr_src) begin
      src_addr <= cfg_wdata.addr.addr;
    end else if (step) begin
      // Next source word
      src_addr <= src_addr + 1'b1;
    end

    if (wr_dst) begin
      dst_addr <= cfg_wdata.addr.addr;
    end else if (step) begin
      // Destinations ascend in step with the source
      dst_addr <= dst_addr + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Length counter, request and done

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      remaining <= '0;
      req       <= 1'b0;
      done      <= 1'b0;
    end else begin
      // Done is a single-cycle pulse by default
      done <= 1'b0;

      if (wr_start) begin
        remaining <= cfg_wdata.ctrl.len;
        // Request shows up the cycle after the ctrl write
        req       <= 1'b1;
      end else if (step) begin
        remaining <= remaining - 1'b1;
        if (last_step) begin
          // Drop out of arbitration and flag completion together
          req  <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

/* logic/dma_engine.sv */
module dma_engine (
  input  logic                                clk,
  input  logic                                arst_n,
  // Level from the host, gates new grants only
  input  logic                                run,
  // Channel side
  input  logic [dma_pkg::dma_channels-1:0]    req,
  input  logic [dma_pkg::dma_addr_w-1:0]      src_addr [dma_pkg::dma_channels],
  input  logic [dma_pkg::dma_addr_w-1:0]      dst_addr [dma_pkg::dma_channels],
  output logic [dma_pkg::dma_channels-1:0]    step,
  // Memory port, one-cycle read latency
  output logic                                mem_re,
  output logic                                mem_we,
  output logic [dma_pkg::dma_addr_w-1:0]      mem_addr,
  output logic [dma_pkg::dma_data_w-1:0]      mem_wdata,
  input  logic [dma_pkg::dma_data_w-1:0]      mem_rdata
);

  import dma_pkg::*;

  ////////////////////////////////////////
  // Arbitration

  logic [dma_channels-1:0] gnt;
  logic [dma_channels-1:0] nxt_gnt;
  logic                    arb_en;
  logic [dma_st_w-1:0]     state;

  // Arbitrate only between words, and only while run is high
  assign arb_en = run && (|req) && (state == dma_st_idle);

  dma_arb_rr #(
    .n (dma_channels)
  ) arb0 (
    .req     (req),
    .en      (arb_en),
    .gnt     (gnt),
    .nxt_gnt (nxt_gnt)
  );

  ////////////////////////////////////////
  // Grant register and sequencer

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Last channel marked as last served, so channel 0 leads
      gnt   <= {1'b1, {(dma_channels-1){1'b0}}};
      state <= dma_st_idle;
    end else begin
      // Arbiter holds the old grant whenever it is not enabled
      gnt <= nxt_gnt;

      case (state)
        dma_st_idle: begin
          if (arb_en) begin
            state <= dma_st_read;
          end
        end
        // Read always takes exactly one cycle
        dma_st_read: begin
          state <= dma_st_write;
        end
        // After the write, back to arbitration
        default: begin
          state <= dma_st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Granted channel addresses

  logic [dma_addr_w-1:0] gnt_src;
  logic [dma_addr_w-1:0] gnt_dst;

  // AND-OR mux driven by the one-hot grant
  always_comb begin
    gnt_src = '0;
    gnt_dst = '0;
    for (int c = 0; c < dma_channels; c++) begin
      if (gnt[c]) begin
        gnt_src = gnt_src | src_addr[c];
        gnt_dst = gnt_dst | dst_addr[c];
      end
    end
  end

  ////////////////////////////////////////
  // Memory port

  // Strobes decode straight from the state register
  assign mem_re = (state == dma_st_read);
  assign mem_we = (state == dma_st_write);

  always_comb begin
    case (state)
      dma_st_read: begin
        mem_addr = gnt_src;
      end
      dma_st_write: begin
        mem_addr = gnt_dst;
      end
      default: begin
        // Bus parked at zero between words
        mem_addr = '0;
      end
    endcase
  end

  // Read data arrives in the write cycle and goes straight back out
  assign mem_wdata = mem_rdata;

  // Step steered to the granted channel during its write
  assign step = mem_we ? gnt : '0;

endmodule

/* logic/dma_top.sv */
module dma_top (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              run,
  // Host configuration write
  input  logic                              cfg_we,
  input  logic [dma_pkg::dma_chan_w-1:0]    cfg_chan,
  input  logic [1:0]                        cfg_reg,
  input  dma_pkg::dma_cfg_word_t            cfg_wdata,
  // Memory port
  output logic                              mem_re,
  output logic                              mem_we,
  output logic [dma_pkg::dma_addr_w-1:0]    mem_addr,
  output logic [dma_pkg::dma_data_w-1:0]    mem_wdata,
  input  logic [dma_pkg::dma_data_w-1:0]    mem_rdata,
  // Per-channel status
  output logic [dma_pkg::dma_channels-1:0]  busy,
  output logic [dma_pkg::dma_channels-1:0]  done
);

  import dma_pkg::*;

  ////////////////////////////////////////
  // Channel to engine wiring

  logic [dma_channels-1:0] req;
  logic [dma_channels-1:0] step;
  logic [dma_addr_w-1:0]   src_addr [dma_channels];
  logic [dma_addr_w-1:0]   dst_addr [dma_channels];

  // A channel is busy exactly while it requests
  assign busy = req;

  ////////////////////////////////////////
  // Channels

  for (genvar i = 0; i < dma_channels; i++) begin : g_chan
    // Each channel decodes its own index from cfg_chan
    dma_channel #(
      .chan_idx (i)
    ) chan0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .cfg_we    (cfg_we),
      .cfg_chan  (cfg_chan),
      .cfg_reg   (cfg_reg),
      .cfg_wdata (cfg_wdata),
      .step      (step[i]),
      .req       (req[i]),
      .src_addr  (src_addr[i]),
      .dst_addr  (dst_addr[i]),
      .done      (done[i])
    );
  end

  ////////////////////////////////////////
  // Shared engine

  dma_engine engine0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .req       (req),
    .src_addr  (src_addr),
    .dst_addr  (dst_addr),
    .step      (step),
    .mem_re    (mem_re),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

/* testbench/dma_assert.sv */
module dma_assert (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [dma_pkg::dma_channels-1:0]  gnt,
  input  logic [dma_pkg::dma_channels-1:0]  req,
  input  logic [dma_pkg::dma_channels-1:0]  step,
  input  logic                              mem_re,
  input  logic                              mem_we
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions so far
  int unsigned fails = 0;

  ////////////////////////////////////////
  // Engine protocol

  // Exactly one channel is marked as last served
  gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(gnt))
    else begin
      fails++;
      $error("grant register is not one-hot: %b", gnt);
    end

  // One access per cycle, and a read only for a channel with words left
  re_we_excl: assert property (@(posedge clk) disable iff (!arst_n)
    mem_re |-> !mem_we && |(gnt & req))
    else begin
      fails++;
      $error("read with mem_we high or for a channel without request: gnt %b req %b",
             gnt, req);
    end

  // Read is always followed by its write, under the same grant
  re_then_we: assert property (@(posedge clk) disable iff (!arst_n)
    mem_re |=> mem_we && $stable(gnt))
    else begin
      fails++;
      $error("mem_re not followed by mem_we under the same grant: gnt %b", gnt);
    end

  // Step only ever rides on a write, and only to a channel with words left
  step_with_we: assert property (@(posedge clk) disable iff (!arst_n)
    (|step) |-> mem_we && ((step & ~req) == '0))
    else begin
      fails++;
      $error("step outside a write cycle or to an idle channel: step %b req %b",
             step, req);
    end

endmodule

bind dma_engine dma_assert assert0 (
  .clk    (clk),
  .arst_n (arst_n),
  .gnt    (gnt),
  .req    (req),
  .step   (step),
  .mem_re (mem_re),
  .mem_we (mem_we)
);

/* testbench/dma_checker.sv */
module dma_checker (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              run,
  input  logic                              mem_re,
  input  logic                              mem_we,
  input  logic [dma_pkg::dma_addr_w-1:0]    mem_addr,
  input  logic [dma_pkg::dma_data_w-1:0]    mem_wdata,
  input  logic [dma_pkg::dma_channels-1:0]  busy,
  input  logic [dma_pkg::dma_channels-1:0]  done,
  // Descriptor set of the coming test, taken when load is high
  input  logic                              load,
  input  logic                              test_end,
  input  logic [dma_pkg::dma_addr_w-1:0]    d_src [dma_pkg::dma_channels],
  input  logic [dma_pkg::dma_addr_w-1:0]    d_dst [dma_pkg::dma_channels],
  input  logic [dma_pkg::dma_len_w-1:0]     d_len [dma_pkg::dma_channels],
  output int                                val_errs,
  output int                                seq_errs
);

  timeunit 1ns;
  timeprecision 1ps;

  import dma_pkg::*;

  ////////////////////////////////////////
  // Expected write list

  logic [dma_addr_w-1:0] exp_addr [$];
  logic [dma_data_w-1:0] exp_data [$];
  int                    exp_chan [$];

  // Reset grant marks channel 3 as last served
  int last_gnt = dma_channels - 1;
  int words_left [dma_channels];
  int done_exp [dma_channels];
  int done_seen [dma_channels];
  // Consecutive sampled cycles with run low
  int low_cnt = 0;

  initial begin
    val_errs = 0;
    seq_errs = 0;
    for (int c = 0; c < dma_channels; c++) begin
      words_left[c] = 0;
      done_exp[c] = 0;
      done_seen[c] = 0;
    end
  end

  // Content of a source word, same rule as the memory preload
  function automatic logic [dma_data_w-1:0] source_word(input logic [dma_addr_w-1:0] a);
    source_word = {16'h3c5a ^ a, 16'hffff ^ a};
  endfunction

  // First pending channel after the last served one, wrapping 3 to 0
  function automatic int rr_next(input int last, input logic [dma_channels-1:0] pending);
    int c;
    int pick;
    pick = -1;
    // Walk downward so the nearest successor is kept last
    for (int i = dma_channels; i >= 1; i--) begin
      c = (last + i) % dma_channels;
      if (pending[c]) begin
        pick = c;
      end
    end
    return pick;
  endfunction

  task automatic expand_descriptors();
    int                      rem [dma_channels];
    logic [dma_channels-1:0] pending;
    logic [dma_addr_w-1:0]   off;
    int                      c;
    for (int i = 0; i < dma_channels; i++) begin
      rem[i] = int'(d_len[i]);
      words_left[i] = rem[i];
      done_exp[i] = (rem[i] != 0) ? 1 : 0;
      done_seen[i] = 0;
    end
    forever begin
      for (int i = 0; i < dma_channels; i++) begin
        pending[i] = (rem[i] != 0);
      end
      if (pending == '0) begin
        break;
      end
      // One word per grant, then arbitrate again
      c = rr_next(last_gnt, pending);
      off = dma_addr_w'(int'(d_len[c]) - rem[c]);
      exp_addr.push_back(d_dst[c] + off);
      exp_data.push_back(source_word(d_src[c] + off));
      exp_chan.push_back(c);
      rem[c]--;
      last_gnt = c;
    end
  endtask

  ////////////////////////////////////////
  // Comparing

  task automatic check_write();
    logic [dma_addr_w-1:0] a;
    logic [dma_data_w-1:0] d;
    int                    ch;
    if (exp_addr.size() == 0) begin
      seq_errs++;
      $display("%0t: extra memory write to address %h, none expected", $time, mem_addr);
    end else begin
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      ch = exp_chan.pop_front();
      if (mem_addr !== a) begin
        val_errs++;
        $display("[ERROR] %0t mem_addr expected %h got %h", $time, a, mem_addr);
      end
      if (mem_wdata !== d) begin
        val_errs++;
        $display("[ERROR] %0t mem_wdata expected %h got %h", $time, d, mem_wdata);
      end
      words_left[ch]--;
    end
  endtask

  task automatic check_done(input int c);
    done_seen[c]++;
    // Busy falls on the same edge that raises done
    if (busy[c] !== 1'b0) begin
      val_errs++;
      $display("[ERROR] %0t busy[%0d] expected 0 got %b", $time, c, busy[c]);
    end
    if (words_left[c] != 0) begin
      seq_errs++;
      $display("%0t: done from channel %0d with %0d words still to write",
               $time, c, words_left[c]);
    end
    if (done_seen[c] > done_exp[c]) begin
      seq_errs++;
      $display("%0t: extra done pulse on channel %0d", $time, c);
    end
  endtask

  task automatic close_test();
    if (exp_addr.size() != 0) begin
      seq_errs++;
      $display("%0t: %0d expected writes never happened", $time, exp_addr.size());
    end
    exp_addr.delete();
    exp_data.delete();
    exp_chan.delete();
    for (int c = 0; c < dma_channels; c++) begin
      if (done_seen[c] < done_exp[c]) begin
        seq_errs++;
        $display("%0t: done pulse missing on channel %0d", $time, c);
      end
      done_seen[c] = 0;
      done_exp[c] = 0;
    end
  endtask

  // Samples at the rising edge, before the edge's own updates land
  always @(posedge clk) begin
    if (arst_n) begin
      if (load) begin
        expand_descriptors();
      end
      if (!run) begin
        low_cnt++;
      end else begin
        low_cnt = 0;
      end
      // Word in progress may still finish within two cycles
      if (low_cnt >= 3 && (mem_re || mem_we)) begin
        seq_errs++;
        $display("%0t: memory access while run has been low for %0d cycles", $time, low_cnt);
      end
      if (mem_we) begin
        check_write();
      end
      for (int c = 0; c < dma_channels; c++) begin
        if (done[c]) begin
          check_done(c);
        end
      end
      if (test_end) begin
        close_test();
      end
    end
  end

endmodule

/* testbench/dma_tb.sv */
module dma_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dma_pkg::*;

  ////////////////////////////////////////
  // Run length

  localparam int n_random = 30;
  localparam int max_len_random = 16;
  // Words of the five directed tests plus the random sets at full length
  localparam int test_words = 8 + 4 * 6 + (5 + 2 + 7) + 4 * 5 + 12 +
                              n_random * dma_channels * max_len_random;
  // Descriptor writes, hand-offs and pauses of one test
  localparam int cfg_cycles = 80;
  localparam int cycle_limit = 3 * test_words + (5 + n_random) * cfg_cycles + 200;

  logic                      clk;
  logic                      arst_n;
  logic                      run;
  logic                      cfg_we;
  logic [dma_chan_w-1:0]     cfg_chan;
  logic [1:0]                cfg_reg;
  logic [dma_data_w-1:0]     cfg_wdata;
  logic                      mem_re;
  logic                      mem_we;
  logic [dma_addr_w-1:0]     mem_addr;
  logic [dma_data_w-1:0]     mem_wdata;
  logic [dma_data_w-1:0]     mem_rdata;
  logic [dma_channels-1:0]   busy;
  logic [dma_channels-1:0]   done;

  // Hand-off to the checker
  logic                      load;
  logic                      test_end;
  logic [dma_addr_w-1:0]     d_src [dma_channels];
  logic [dma_addr_w-1:0]     d_dst [dma_channels];
  logic [dma_len_w-1:0]      d_len [dma_channels];
  int                        val_errs;
  int                        seq_errs;

  integer seed = 83655;
  int cycle_cnt = 0;
  logic [dma_data_w-1:0] mem [2**dma_addr_w];

  initial clk = 1'b0;
  always #10 clk = ~clk;

  dma_top dut0 (
    .clk (clk), .arst_n (arst_n), .run (run),
    .cfg_we (cfg_we), .cfg_chan (cfg_chan), .cfg_reg (cfg_reg), .cfg_wdata (cfg_wdata),
    .mem_re (mem_re), .mem_we (mem_we), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_rdata (mem_rdata), .busy (busy), .done (done)
  );

  dma_checker chk0 (
    .clk (clk), .arst_n (arst_n), .run (run), .mem_re (mem_re), .mem_we (mem_we),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata), .busy (busy), .done (done),
    .load (load), .test_end (test_end), .d_src (d_src), .d_dst (d_dst), .d_len (d_len),
    .val_errs (val_errs), .seq_errs (seq_errs)
  );

  ////////////////////////////////////////
  // Memory model

  function automatic logic [dma_data_w-1:0] fill_word(input logic [dma_addr_w-1:0] a);
    fill_word = {a ^ 16'h3c5a, ~a};
  endfunction

  // Read data valid in the cycle after mem_re
  always @(posedge clk) begin
    if (mem_re) begin
      mem_rdata <= mem[mem_addr];
    end
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: simulation ran past %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Host tasks

  task automatic cfg_write(input int chan, input logic [1:0] sel, input logic [31:0] data);
    @(posedge clk);
    cfg_we <= 1'b1;
    cfg_chan <= dma_chan_w'(chan);
    cfg_reg <= sel;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  // Source, destination, then ctrl with start set
  task automatic program_channel(input int chan, input logic [15:0] src,
                                 input logic [15:0] dst, input logic [15:0] len);
    cfg_write(chan, dma_reg_src, 32'(src));
    cfg_write(chan, dma_reg_dst, 32'(dst));
    cfg_write(chan, dma_reg_ctrl, 32'h8000_0000 | 32'(len));
    d_src[chan] <= src;
    d_dst[chan] <= dst;
    d_len[chan] <= len;
  endtask

  task automatic clear_descriptors();
    for (int c = 0; c < dma_channels; c++) begin
      d_src[c] <= '0;
      d_dst[c] <= '0;
      d_len[c] <= '0;
    end
  endtask

  task automatic start_check();
    @(posedge clk);
    load <= 1'b1;
    @(posedge clk);
    load <= 1'b0;
    run <= 1'b1;
  endtask

  // Busy falls with the last done, then the checker closes the test
  task automatic finish_test();
    @(posedge clk);
    while (busy != '0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    run <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Tests

  initial begin
    logic [15:0] r_src;
    logic [15:0] r_dst;
    logic [15:0] r_len;
    int total;
    arst_n = 1'b0;
    run = 1'b0;
    cfg_we = 1'b0;
    cfg_chan = '0;
    cfg_reg = '0;
    cfg_wdata = '0;
    mem_rdata = '0;
    load = 1'b0;
    test_end = 1'b0;
    for (int c = 0; c < dma_channels; c++) begin
      d_src[c] = '0;
      d_dst[c] = '0;
      d_len[c] = '0;
    end
    // Every word carries its own address
    for (int a = 0; a < 2**dma_addr_w; a++) begin
      mem[a] = fill_word(dma_addr_w'(a));
    end
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    // Sources in the lower half, destinations in the upper half
    // Single channel copy
    clear_descriptors();
    program_channel(0, 16'h0100, 16'h8100, 16'd8);
    start_check();
    finish_test();

    // All four channels, equal lengths
    clear_descriptors();
    for (int c = 0; c < dma_channels; c++) begin
      program_channel(c, 16'(c * 16'h1000 + 16'h40), 16'(16'h8040 + c * 16'h1000), 16'd6);
    end
    start_check();
    finish_test();

    // Subset with unequal lengths, channel 1 left idle
    clear_descriptors();
    program_channel(0, 16'h0200, 16'h8200, 16'd5);
    program_channel(2, 16'h2200, 16'ha200, 16'd2);
    program_channel(3, 16'h3200, 16'hb200, 16'd7);
    start_check();
    finish_test();

    // Run paused in the middle
    clear_descriptors();
    for (int c = 0; c < dma_channels; c++) begin
      program_channel(c, 16'(c * 16'h1000 + 16'h300), 16'(16'h8300 + c * 16'h1000), 16'd5);
    end
    start_check();
    repeat (10) @(posedge clk);
    run <= 1'b0;
    repeat (12) @(posedge clk);
    run <= 1'b1;
    finish_test();

    // Reconfiguration of a busy channel, zero-length start on an idle one
    clear_descriptors();
    program_channel(1, 16'h1200, 16'h9200, 16'd12);
    start_check();
    repeat (6) @(posedge clk);
    cfg_write(1, dma_reg_src, 32'h0000_1700);
    cfg_write(1, dma_reg_dst, 32'h0000_9700);
    cfg_write(1, dma_reg_ctrl, 32'h8000_0000);
    cfg_write(1, dma_reg_ctrl, 32'h8000_0003);
    cfg_write(2, dma_reg_ctrl, 32'h8000_0000);
    finish_test();

    // Random descriptor sets, one 4K region per channel on each side
    for (int t = 0; t < n_random; t++) begin
      clear_descriptors();
      for (int c = 0; c < dma_channels; c++) begin
        r_src = 16'(c * 16'h1000 + $unsigned($random(seed)) % 16'h0f00);
        r_dst = 16'(16'h8000 + c * 16'h1000 + $unsigned($random(seed)) % 16'h0f00);
        r_len = 16'($unsigned($random(seed)) % (max_len_random + 1));
        program_channel(c, r_src, r_dst, r_len);
      end
      start_check();
      finish_test();
    end

    repeat (4) @(posedge clk);
    total = val_errs + seq_errs + int'(dut0.engine0.assert0.fails);
    $display("Checks finished: %0d value errors, %0d sequence errors, %0d assertion failures",
             val_errs, seq_errs, dut0.engine0.assert0.fails);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
logic/dma_pkg.sv
logic/dma_arb_rr.sv
logic/dma_channel.sv
logic/dma_engine.sv
logic/dma_top.sv
testbench/dma_assert.sv
testbench/dma_checker.sv
testbench/dma_tb.sv
